/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_ahb_matrix
FILELIST  := src.f
BUILD_DIR := obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* ahb_async_matrix_top.sv */
`timescale 1ns/1ps

`include "ahb_bridge_defs.svh"

module ahb_async_matrix_top
  import ahb_pkg::*, bridge_pkg::*;
(
  input  logic                   main_hclk,
  input  logic                   main_hresetn,
  input  logic                   sub_hclk,
  input  logic                   sub_hresetn,
  input  ahb_mst_req_t           m_req,
  input  logic [`AHB_DATA_W-1:0] m_hwdata,
  output logic                   m_hready,
  output rsp_word_t              m_rsp_data,
  output ahb_slv_req_t           s_req [`SLV_NUM],
  input  ahb_slv_rsp_t           s_rsp [`SLV_NUM]
);

  logic         cmd_push;
  logic         cmd_full;
  logic         cmd_pop;
  logic         cmd_empty;
  cmd_word_t    cmd_wr;
  cmd_word_t    cmd_rd;
  logic         rsp_push;
  logic         rsp_full;
  logic         rsp_pop;
  logic         rsp_empty;
  rsp_word_t    rsp_wr;
  rsp_word_t    rsp_rd;
  cmd_word_t    slv_cmd;
  logic         addr_phase;
  logic         data_phase;
  ahb_slv_rsp_t slv_rsp;

  main_side_ctrl main_ctrl_i (
    .main_hclk    (main_hclk),
    .main_hresetn (main_hresetn),
    .m_req        (m_req),
    .m_hwdata     (m_hwdata),
    .m_hready     (m_hready),
    .m_rsp_data   (m_rsp_data),
    .cmd_push     (cmd_push),
    .cmd_word     (cmd_wr),
    .cmd_full     (cmd_full),
    .rsp_empty    (rsp_empty),
    .rsp_pop      (rsp_pop),
    .rsp_word     (rsp_rd)
  );

  async_fifo #(
    .WIDTH ($bits(cmd_word_t)),
    .DEPTH (`BRIDGE_FIFO_DEPTH)
  ) cmd_fifo_i (
    .wr_clk    (main_hclk),
    .wr_resetn (main_hresetn),
    .wr_en     (cmd_push),
    .wr_data   (cmd_wr),
    .wr_full   (cmd_full),
    .rd_clk    (sub_hclk),
    .rd_resetn (sub_hresetn),
    .rd_en     (cmd_pop),
    .rd_data   (cmd_rd),
    .rd_empty  (cmd_empty)
  );

  async_fifo #(
    .WIDTH ($bits(rsp_word_t)),
    .DEPTH (`BRIDGE_FIFO_DEPTH)
  ) rsp_fifo_i (
    .wr_clk    (sub_hclk),
    .wr_resetn (sub_hresetn),
    .wr_en     (rsp_push),
    .wr_data   (rsp_wr),
    .wr_full   (rsp_full),
    .rd_clk    (main_hclk),
    .rd_resetn (main_hresetn),
    .rd_en     (rsp_pop),
    .rd_data   (rsp_rd),
    .rd_empty  (rsp_empty)
  );

  sub_side_ctrl sub_ctrl_i (
    .sub_hclk    (sub_hclk),
    .sub_hresetn (sub_hresetn),
    .cmd_empty   (cmd_empty),
    .cmd_word    (cmd_rd),
    .cmd_pop     (cmd_pop),
    .slv_cmd     (slv_cmd),
    .addr_phase  (addr_phase),
    .data_phase  (data_phase),
    .slv_rsp     (slv_rsp),
    .rsp_full    (rsp_full),
    .rsp_push    (rsp_push),
    .rsp_word    (rsp_wr)
  );

  slave_decoder decoder_i (
    .sub_hclk    (sub_hclk),
    .sub_hresetn (sub_hresetn),
    .slv_cmd     (slv_cmd),
    .addr_phase  (addr_phase),
    .data_phase  (data_phase),
    .s_req       (s_req),
    .s_rsp       (s_rsp),
    .slv_rsp     (slv_rsp)
  );

endmodule

/* ahb_bridge_defs.svh */
`ifndef AHB_BRIDGE_DEFS_SVH
`define AHB_BRIDGE_DEFS_SVH

// bus widths of the master and slave ports
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// each clock-crossing FIFO holds a power-of-two number of entries
`define BRIDGE_FIFO_DEPTH 4

// slave map with one window per 256 MB
`define SLV_NUM 6
`define SLV_WIN_BITS 30:28

`endif

/* ahb_pkg.sv */
`include "ahb_bridge_defs.svh"

package ahb_pkg;

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [1:0] {
    HRESP_OKAY  = 2'b00,
    HRESP_ERROR = 2'b01
  } hresp_e;

  // address phase as seen from the single master
  typedef struct packed {
    logic                   hselx;
    htrans_e                htrans;
    logic                   hwrite;
    logic [2:0]             hsize;
    logic [`AHB_ADDR_W-1:0] haddr;
  } ahb_mst_req_t;

  typedef struct packed {
    logic                   hselx;
    htrans_e                htrans;
    logic                   hwrite;
    logic [2:0]             hsize;
    logic [`AHB_ADDR_W-1:0] haddr;
    logic [`AHB_DATA_W-1:0] hwdata;
  } ahb_slv_req_t;

  typedef struct packed {
    logic                   hready;
    hresp_e                 hresp;
    logic [`AHB_DATA_W-1:0] hrdata;
  } ahb_slv_rsp_t;

endpackage

/* async_fifo.sv */
`timescale 1ns/1ps

module async_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             wr_clk,
  input  logic             wr_resetn,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  output logic             wr_full,
  input  logic             rd_clk,
  input  logic             rd_resetn,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             rd_empty
);

  localparam int AW = $clog2(DEPTH);
  // the two top gray bits differ when the writer is one lap ahead
  localparam logic [AW:0] FULL_MASK = (AW+1)'(3) << (AW - 1);

  logic [WIDTH-1:0] mem [DEPTH];

  logic [AW:0] wr_bin;
  logic [AW:0] wr_gray;
  logic [AW:0] wr_bin_nxt;
  logic [AW:0] wr_gray_nxt;
  logic [AW:0] rd_bin;
  logic [AW:0] rd_gray;
  logic [AW:0] rd_bin_nxt;
  logic [AW:0] rd_gray_nxt;
  logic [AW:0] rd_gray_w1;
  logic [AW:0] rd_gray_w2;
  logic [AW:0] wr_gray_r1;
  logic [AW:0] wr_gray_r2;

  assign wr_bin_nxt  = wr_bin + 1'b1;
  assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);
  assign rd_bin_nxt  = rd_bin + 1'b1;
  assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);

  always_ff @(posedge wr_clk)
  begin
    if (wr_en && !wr_full)
    begin
      mem[wr_bin[AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_resetn)
  begin
    if (!wr_resetn)
    begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
    end
    else
    begin
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
      if (wr_en && !wr_full)
      begin
        wr_bin  <= wr_bin_nxt;
        wr_gray <= wr_gray_nxt;
      end
    end
  end

  always_ff @(posedge rd_clk or negedge rd_resetn)
  begin
    if (!rd_resetn)
    begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
    end
    else
    begin
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
      if (rd_en && !rd_empty)
      begin
        rd_bin  <= rd_bin_nxt;
        rd_gray <= rd_gray_nxt;
      end
    end
  end

  assign wr_full  = (wr_gray == (rd_gray_w2 ^ FULL_MASK));
  assign rd_empty = (rd_gray == wr_gray_r2);
  assign rd_data  = mem[rd_bin[AW-1:0]];

endmodule

/* bridge_pkg.sv */
`include "ahb_bridge_defs.svh"

package bridge_pkg;

  import ahb_pkg::*;

  // one complete single transfer, sent from the main to the sub domain
  typedef struct packed {
    logic [`AHB_ADDR_W-1:0] haddr;
    logic                   hwrite;
    logic [2:0]             hsize;
    logic [`AHB_DATA_W-1:0] hwdata;
  } cmd_word_t;

  // slave answer, sent back to the main domain
  typedef struct packed {
    hresp_e                 hresp;
    logic [`AHB_DATA_W-1:0] hrdata;
  } rsp_word_t;

  typedef logic [2:0] slv_idx_t;

endpackage

/* main_side_ctrl.sv */
`timescale 1ns/1ps

`include "ahb_bridge_defs.svh"

module main_side_ctrl
  import ahb_pkg::*, bridge_pkg::*;
(
  input  logic                   main_hclk,
  input  logic                   main_hresetn,
  input  ahb_mst_req_t           m_req,
  input  logic [`AHB_DATA_W-1:0] m_hwdata,
  output logic                   m_hready,
  output rsp_word_t              m_rsp_data,
  output logic                   cmd_push,
  output cmd_word_t              cmd_word,
  input  logic                   cmd_full,
  input  logic                   rsp_empty,
  output logic                   rsp_pop,
  input  rsp_word_t              rsp_word
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PUSH,
    ST_WAIT
  } state_e;

  state_e       state;
  ahb_mst_req_t addr_q;
  rsp_word_t    rsp_q;
  logic         start;

  // only a selected NONSEQ goes across, everything else finishes at once
  assign start = (state == ST_IDLE) && m_req.hselx && (m_req.htrans == HTRANS_NONSEQ);

  always_ff @(posedge main_hclk)
  begin
    if (start)
    begin
      addr_q <= m_req;
    end
  end

  always_ff @(posedge main_hclk or negedge main_hresetn)
  begin
    if (!main_hresetn)
    begin
      state <= ST_IDLE;
      rsp_q <= '0;
    end
    else
    begin
      // the popped answer is shown for a single cycle, then OKAY again
      rsp_q <= rsp_pop ? rsp_word : '0;
      case (state)
        ST_IDLE:
        begin
          if (start)
          begin
            state <= ST_PUSH;
          end
        end
        ST_PUSH:
        begin
          if (!cmd_full)
          begin
            state <= ST_WAIT;
          end
        end
        default:
        begin
          if (!rsp_empty)
          begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // hwdata belongs to the cycle after the address phase and is held while hready is low
  assign cmd_word = '{haddr: addr_q.haddr, hwrite: addr_q.hwrite,
                      hsize: addr_q.hsize, hwdata: m_hwdata};
  assign cmd_push   = (state == ST_PUSH) && !cmd_full;
  assign rsp_pop    = (state == ST_WAIT) && !rsp_empty;
  assign m_hready   = (state == ST_IDLE);
  assign m_rsp_data = rsp_q;

endmodule

/* matrix_trace.txt */
# op addr wdata exp_rdata exp_resp, op is W write, R read or I idle (addr = idle cycles)
# exp_resp is 0 for OKAY and 1 for ERROR, all values in hex
W 00000010 a5a5a5a5 00000000 0
R 00000010 00000000 a5a5a5a5 0
W 10000020 11112222 00000000 0
R 10000020 00000000 11112222 0
R 10000024 00000000 00000000 0
W 20000030 deadbeef 00000000 0
R 20000030 00000000 deadbeef 0
I 00000004 00000000 00000000 0
W 30000040 0badf00d 00000000 0
R 30000040 00000000 0badf00d 0
W 40000050 12345678 00000000 0
R 40000050 00000000 12345678 0
R 40000054 00000000 00000000 0
W 50000060 cafef00d 00000000 0
R 50000060 00000000 cafef00d 0
W 60000000 ffffffff 00000000 1
R 70000010 00000000 00000000 1
I 00000003 00000000 00000000 0
R 00000010 00000000 a5a5a5a5 0
W 500003fc 89abcdef 00000000 0
R 500003fc 00000000 89abcdef 0
R 00000014 00000000 00000000 0

/* slave_decoder.sv */
`timescale 1ns/1ps

`include "ahb_bridge_defs.svh"

module slave_decoder
  import ahb_pkg::*, bridge_pkg::*;
(
  input  logic         sub_hclk,
  input  logic         sub_hresetn,
  input  cmd_word_t    slv_cmd,
  input  logic         addr_phase,
  input  logic         data_phase,
  output ahb_slv_req_t s_req [`SLV_NUM],
  input  ahb_slv_rsp_t s_rsp [`SLV_NUM],
  output ahb_slv_rsp_t slv_rsp
);

  slv_idx_t             win_idx;
  slv_idx_t             idx_q;
  logic [`SLV_NUM-1:0]  addr_sel;
  logic [`SLV_NUM-1:0]  data_sel;

  assign win_idx = slv_cmd.haddr[`SLV_WIN_BITS];

  // the data phase follows the slave chosen in the address phase
  always_ff @(posedge sub_hclk or negedge sub_hresetn)
  begin
    if (!sub_hresetn)
    begin
      idx_q <= '0;
    end
    else if (addr_phase)
    begin
      idx_q <= win_idx;
    end
  end

  always_comb
  begin
    for (int k = 0; k < `SLV_NUM; k++)
    begin
      addr_sel[k] = addr_phase && (win_idx == slv_idx_t'(k));
      data_sel[k] = data_phase && (idx_q == slv_idx_t'(k));
    end
  end

  always_comb
  begin
    for (int k = 0; k < `SLV_NUM; k++)
    begin
      s_req[k].hselx  = addr_sel[k];
      s_req[k].htrans = addr_sel[k] ? HTRANS_NONSEQ : HTRANS_IDLE;
      s_req[k].hwrite = slv_cmd.hwrite;
      s_req[k].hsize  = slv_cmd.hsize;
      s_req[k].haddr  = slv_cmd.haddr;
      s_req[k].hwdata = data_sel[k] ? slv_cmd.hwdata : '0;
    end
  end

  // windows 6 and 7 fall through to the local error slave
  always_comb
  begin
    slv_rsp.hready = 1'b1;
    slv_rsp.hresp  = HRESP_ERROR;
    slv_rsp.hrdata = '0;
    for (int k = 0; k < `SLV_NUM; k++)
    begin
      if (idx_q == slv_idx_t'(k))
      begin
        slv_rsp = s_rsp[k];
      end
    end
  end

endmodule

/* src.f */
+incdir+.
ahb_pkg.sv
bridge_pkg.sv
async_fifo.sv
main_side_ctrl.sv
sub_side_ctrl.sv
slave_decoder.sv
ahb_async_matrix_top.sv
tb_ahb_slave_mem.sv
tb_ahb_matrix.sv

/* sub_side_ctrl.sv */
`timescale 1ns/1ps

module sub_side_ctrl
  import ahb_pkg::*, bridge_pkg::*;
(
  input  logic         sub_hclk,
  input  logic         sub_hresetn,
  input  logic         cmd_empty,
  input  cmd_word_t    cmd_word,
  output logic         cmd_pop,
  output cmd_word_t    slv_cmd,
  output logic         addr_phase,
  output logic         data_phase,
  input  ahb_slv_rsp_t slv_rsp,
  input  logic         rsp_full,
  output logic         rsp_push,
  output rsp_word_t    rsp_word
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_PUSH
  } state_e;

  state_e    state;
  cmd_word_t cmd_q;
  rsp_word_t rsp_q;

  // the head entry is copied on entry to the address phase and popped at its end
  always_ff @(posedge sub_hclk)
  begin
    if ((state == ST_IDLE) && !cmd_empty)
    begin
      cmd_q <= cmd_word;
    end
    if ((state == ST_DATA) && slv_rsp.hready)
    begin
      rsp_q.hresp  <= slv_rsp.hresp;
      rsp_q.hrdata <= slv_rsp.hrdata;
    end
  end

  always_ff @(posedge sub_hclk or negedge sub_hresetn)
  begin
    if (!sub_hresetn)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (!cmd_empty)
          begin
            state <= ST_ADDR;
          end
        end
        ST_ADDR:
        begin
          state <= ST_DATA;
        end
        ST_DATA:
        begin
          // a slow slave stretches this state
          if (slv_rsp.hready)
          begin
            state <= ST_PUSH;
          end
        end
        default:
        begin
          if (!rsp_full)
          begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  assign cmd_pop    = (state == ST_ADDR);
  assign addr_phase = (state == ST_ADDR);
  assign data_phase = (state == ST_DATA);
  assign rsp_push   = (state == ST_PUSH) && !rsp_full;
  assign slv_cmd    = cmd_q;
  assign rsp_word   = rsp_q;

endmodule

/* tb_ahb_matrix.sv */
`timescale 1ns/1ps

`include "ahb_bridge_defs.svh"

module tb_ahb_matrix
  import ahb_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic                   main_hclk;
  logic                   main_hresetn;
  logic                   sub_hclk;
  logic                   sub_hresetn;
  ahb_mst_req_t           m_req;
  logic [`AHB_DATA_W-1:0] m_hwdata;
  logic                   m_hready;
  bridge_pkg::rsp_word_t  m_rsp_data;
  ahb_slv_req_t           s_req [`SLV_NUM];
  ahb_slv_rsp_t           s_rsp [`SLV_NUM];
  int unsigned            sel_count [`SLV_NUM];
  int unsigned            miss_count [`SLV_NUM];
  int unsigned            exp_count [`SLV_NUM];

  int                     fd;
  int                     n;
  logic [7:0]             op;
  logic [31:0]            tr_addr;
  logic [31:0]            tr_wdata;
  logic [31:0]            tr_rdata;
  logic [1:0]             tr_resp;
  logic [8*128-1:0]       rest;

  ahb_async_matrix_top dut_i (
    .main_hclk    (main_hclk),
    .main_hresetn (main_hresetn),
    .sub_hclk     (sub_hclk),
    .sub_hresetn  (sub_hresetn),
    .m_req        (m_req),
    .m_hwdata     (m_hwdata),
    .m_hready     (m_hready),
    .m_rsp_data   (m_rsp_data),
    .s_req        (s_req),
    .s_rsp        (s_rsp)
  );

  for (genvar k = 0; k < `SLV_NUM; k++)
  begin : g_slave
    tb_ahb_slave_mem #(.IDX(k)) slave_i (
      .hclk       (sub_hclk),
      .hresetn    (sub_hresetn),
      .req        (s_req[k]),
      .rsp        (s_rsp[k]),
      .sel_count  (sel_count[k]),
      .miss_count (miss_count[k])
    );
  end

  always
  begin
    #2 main_hclk = ~main_hclk;
  end

  always
  begin
    #5 sub_hclk = ~sub_hclk;
  end

  task automatic stop_on_error();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_slave_counts();
    for (int k = 0; k < `SLV_NUM; k++)
    begin
      check_value($sformatf("sel_count[%0d]", k), sel_count[k], exp_count[k]);
      check_value($sformatf("miss_count[%0d]", k), miss_count[k], 32'd0);
    end
  endtask

  // called on a falling edge while m_hready is high, returns on the completing falling edge
  task automatic run_transfer(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp_rdata,
                              input logic [1:0] exp_resp);
    int cycles;
    int win;
    cycles = 0;
    win = int'(addr[30:28]);
    if (win < `SLV_NUM)
    begin
      exp_count[win]++;
    end
    m_req = '{hselx: 1'b1, htrans: HTRANS_NONSEQ, hwrite: is_write, hsize: 3'd2, haddr: addr};
    @(negedge main_hclk);
    check_value("m_hready", 32'(m_hready), 32'd0);
    m_req = '0;
    m_hwdata = wdata;
    while (!m_hready && (cycles < WAIT_LIMIT))
    begin
      @(negedge main_hclk);
      cycles++;
    end
    assert (m_hready)
    else
    begin
      $display("m_hready stayed low for %0d cycles on the transfer to %h", cycles, addr);
      stop_on_error();
    end
    check_value("m_rsp_data.hresp", 32'(m_rsp_data.hresp), 32'(exp_resp));
    check_value("m_rsp_data.hrdata", m_rsp_data.hrdata, exp_rdata);
    check_slave_counts();
  endtask

  task automatic run_idle(input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      // a selected IDLE and an unselected NONSEQ must both finish at once
      if ((i % 2) == 0)
      begin
        m_req = '{hselx: 1'b1, htrans: HTRANS_IDLE, hwrite: 1'b1, hsize: 3'd2,
                  haddr: 32'h1000_0000};
      end
      else
      begin
        m_req = '{hselx: 1'b0, htrans: HTRANS_NONSEQ, hwrite: 1'b0, hsize: 3'd2,
                  haddr: 32'h2000_0000};
      end
      @(negedge main_hclk);
      check_value("m_hready", 32'(m_hready), 32'd1);
      check_value("m_rsp_data.hresp", 32'(m_rsp_data.hresp), 32'(HRESP_OKAY));
    end
    m_req = '0;
    check_slave_counts();
  endtask

  initial
  begin
    main_hclk    = 1'b0;
    sub_hclk     = 1'b0;
    main_hresetn = 1'b0;
    sub_hresetn  = 1'b0;
    m_req        = '0;
    m_hwdata     = '0;
    for (int k = 0; k < `SLV_NUM; k++)
    begin
      exp_count[k] = 0;
    end
    repeat (3) @(posedge main_hclk);
    @(negedge main_hclk);
    main_hresetn = 1'b1;
    sub_hresetn  = 1'b1;
    @(negedge main_hclk);
    check_value("m_hready", 32'(m_hready), 32'd1);
    check_value("m_rsp_data.hresp", 32'(m_rsp_data.hresp), 32'(HRESP_OKAY));
    check_value("m_rsp_data.hrdata", m_rsp_data.hrdata, 32'd0);

    fd = $fopen("matrix_trace.txt", "r");
    assert (fd != 0)
    else
    begin
      $display("the trace file matrix_trace.txt could not be opened");
      stop_on_error();
    end
    n = $fscanf(fd, " %c", op);
    while (n == 1)
    begin
      if (op == "#")
      begin
        n = $fgets(rest, fd);
      end
      else
      begin
        n = $fscanf(fd, " %h %h %h %h", tr_addr, tr_wdata, tr_rdata, tr_resp);
        assert (n == 4)
        else
        begin
          $display("a trace line for operation %c has missing columns", op);
          stop_on_error();
        end
        case (op)
          "W": run_transfer(1'b1, tr_addr, tr_wdata, tr_rdata, tr_resp);
          "R": run_transfer(1'b0, tr_addr, tr_wdata, tr_rdata, tr_resp);
          "I": run_idle(int'(tr_addr));
          default:
          begin
            $display("the trace holds an unknown operation %c", op);
            stop_on_error();
          end
        endcase
      end
      n = $fscanf(fd, " %c", op);
    end
    $fclose(fd);
    run_idle(4);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* tb_ahb_slave_mem.sv */
`timescale 1ns/1ps

module tb_ahb_slave_mem
  import ahb_pkg::*;
#(
  parameter int IDX = 0
) (
  input  logic         hclk,
  input  logic         hresetn,
  input  ahb_slv_req_t req,
  output ahb_slv_rsp_t rsp,
  output int unsigned  sel_count,
  output int unsigned  miss_count
);

  logic [31:0] mem [256];
  logic [31:0] lcg_state;
  logic        pending;
  logic        write_q;
  logic [7:0]  word_q;
  logic [1:0]  waits;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge hclk or negedge hresetn)
  begin
    if (!hresetn)
    begin
      for (int i = 0; i < 256; i++)
      begin
        mem[i] <= '0;
      end
      lcg_state  <= 32'h5c0b;
      pending    <= 1'b0;
      write_q    <= 1'b0;
      word_q     <= '0;
      waits      <= '0;
      sel_count  <= 0;
      miss_count <= 0;
    end
    else
    begin
      if (pending)
      begin
        if (waits != 2'd0)
        begin
          waits <= waits - 2'd1;
        end
        else
        begin
          pending <= 1'b0;
          if (write_q)
          begin
            mem[word_q] <= req.hwdata;
          end
        end
      end
      if (req.hselx)
      begin
        sel_count <= sel_count + 1;
        // the decoder must route by window and pass on the word size the master sends
        if ((req.haddr[30:28] != 3'(IDX)) || (req.hsize != 3'd2))
        begin
          miss_count <= miss_count + 1;
        end
      end
      if (req.hselx && (req.htrans == HTRANS_NONSEQ))
      begin
        pending   <= 1'b1;
        write_q   <= req.hwrite;
        word_q    <= req.haddr[9:2];
        waits     <= lcg_state[17:16];
        lcg_state <= lcg_next(lcg_state);
      end
    end
  end

  always_comb
  begin
    rsp.hready = !pending || (waits == 2'd0);
    rsp.hresp  = HRESP_OKAY;
    rsp.hrdata = (pending && !write_q) ? mem[word_q] : '0;
  end

endmodule
